// File: flist.f
rtl/riscv_pkg.sv
rtl/mem_if.sv
rtl/register_file.sv
rtl/riscv_core.sv
rtl/rom.sv
rtl/ram_interface.sv
rtl/ram.sv
rtl/riscv_soc.sv
tb/riscv_soc_sva.sv
tb/riscv_soc_tb.sv

// File: rtl/mem_if.sv
interface mem_bus_if;
    import riscv_pkg::*;

    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    logic [XLEN-1:0] mem_rdata;
    logic [1:0]      mem_type;
    logic            mem_sign; // sign-extend the loaded lane.
    logic            rmem;
    logic            wmem;

    modport core   (output mem_addr, mem_wdata, mem_type, mem_sign, rmem, wmem, input mem_rdata);
    modport bridge (input mem_addr, mem_wdata, mem_type, mem_sign, rmem, wmem, output mem_rdata);
endinterface

interface ram_port_if;
    import riscv_pkg::*;

    logic [3:0]      wen; // one enable per byte lane.
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] w_data;
    logic            ren;
    logic [XLEN-1:0] r_data;

    modport bridge (output wen, addr, w_data, ren, input r_data);
    modport ram    (input wen, addr, w_data, ren, output r_data);
endinterface

// File: rtl/ram.sv
module ram #(
    parameter int MEM_NUM = 2 ** riscv_pkg::RAM_AW
) (
    input logic  clk,
    ram_port_if.ram ram
);
    import riscv_pkg::*;

    logic [XLEN-1:0]   mem [MEM_NUM];
    logic [RAM_AW-1:0] idx;

    assign idx = ram.addr[RAM_AW+1:2]; // byte address to word index.

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (ram.wen[i]) begin
                mem[idx][8*i +: 8] <= ram.w_data[8*i +: 8];
            end
        end
        if (ram.ren) begin
            ram.r_data <= mem[idx]; // old data on a same-cycle write.
        end
    end
endmodule

// File: rtl/ram_interface.sv
module ram_interface (
    input  logic       clk,
    input  logic       reset,
    mem_bus_if.bridge  mem,
    ram_port_if.bridge ram
);
    import riscv_pkg::*;

    logic [1:0]  off;
    logic [3:0]  lanes;
    logic [1:0]  ld_type;
    logic        ld_sign;
    logic [1:0]  ld_off;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign off = mem.mem_addr[1:0];

    always_comb begin
        case (mem.mem_type)
            MEM_BYTE: begin
                lanes      = 4'b0001 << off;
                ram.w_data = {4{mem.mem_wdata[7:0]}};
            end
            MEM_HALF: begin
                lanes      = off[1] ? 4'b1100 : 4'b0011;
                ram.w_data = {2{mem.mem_wdata[15:0]}};
            end
            default: begin
                lanes      = 4'b1111;
                ram.w_data = mem.mem_wdata;
            end
        endcase
    end

    assign ram.wen  = mem.wmem ? lanes : 4'b0000;
    assign ram.addr = mem.mem_addr;
    assign ram.ren  = mem.rmem;

    // the RAM answers next cycle, so keep what the load asked for.
    always_ff @(posedge clk) begin
        if (reset) begin
            ld_type <= MEM_WORD;
            ld_sign <= 1'b0;
            ld_off  <= 2'd0;
        end else if (mem.rmem) begin
            ld_type <= mem.mem_type;
            ld_sign <= mem.mem_sign;
            ld_off  <= off;
        end
    end

    assign ld_byte = ram.r_data[{ld_off, 3'b000} +: 8];
    assign ld_half = ld_off[1] ? ram.r_data[31:16] : ram.r_data[15:0];

    always_comb begin
        case (ld_type)
            MEM_BYTE: mem.mem_rdata = {{24{ld_sign & ld_byte[7]}}, ld_byte};
            MEM_HALF: mem.mem_rdata = {{16{ld_sign & ld_half[15]}}, ld_half};
            default:  mem.mem_rdata = ram.r_data;
        endcase
    end
endmodule

// File: rtl/register_file.sv
module register_file (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [4:0]                 rs1_addr,
    input  logic [4:0]                 rs2_addr,
    input  logic                       rd_we,
    input  logic [4:0]                 rd_addr,
    input  logic [riscv_pkg::XLEN-1:0] rd_data,
    output logic [riscv_pkg::XLEN-1:0] rs1_data,
    output logic [riscv_pkg::XLEN-1:0] rs2_data,
    output logic                       over,
    output logic                       pass
);
    import riscv_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    assign over = regs[OVER_REG][0]; // the testbench watches these two bits.
    assign pass = regs[PASS_REG][0];
endmodule

// File: rtl/riscv_core.sv
module riscv_core (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [riscv_pkg::XLEN-1:0]   inst_rom,
    output logic [riscv_pkg::ROM_AW-1:0] inst_addr_rom,
    output logic                         over,
    output logic                         pass,
    mem_bus_if.core                      mem
);
    import riscv_pkg::*;

    logic [XLEN-1:0] fetch_pc;
    logic [XLEN-1:0] ex_pc;
    logic            ex_valid;
    logic            load_wait;
    instr_u          ir;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] rd_data;
    logic            rd_we;
    logic            stall;
    logic            take;

    assign ir     = inst_rom; // the ROM output register is the fetch stage.
    assign opcode = ir.r_view.opcode;
    assign funct3 = ir.r_view.funct3;

    assign imm_i = {{20{ir.i_view.imm_11_0[11]}}, ir.i_view.imm_11_0};
    assign imm_s = {{20{ir.s_view.imm_11_5[6]}}, ir.s_view.imm_11_5, ir.s_view.imm_4_0};
    assign imm_b = {{19{ir.s_view.imm_11_5[6]}}, ir.s_view.imm_11_5[6], ir.s_view.imm_4_0[0],
                    ir.s_view.imm_11_5[5:0], ir.s_view.imm_4_0[4:1], 1'b0};
    assign imm_j = {{11{ir.u_view.imm_31_12[19]}}, ir.u_view.imm_31_12[19],
                    ir.u_view.imm_31_12[7:0], ir.u_view.imm_31_12[8],
                    ir.u_view.imm_31_12[18:9], 1'b0};
    assign imm_u = {ir.u_view.imm_31_12, 12'b0};

    register_file register_inst (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (ir.r_view.rs1),
        .rs2_addr (ir.r_view.rs2),
        .rd_we    (rd_we),
        .rd_addr  (ir.r_view.rd),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .over     (over),
        .pass     (pass)
    );

    assign alu_b = (opcode == OP_OP) ? rs2_data : imm_i;

    always_comb begin
        case (funct3)
            3'b000:  alu_out = (opcode == OP_OP && ir.r_view.funct7[5]) ? rs1_data - alu_b
                                                                          : rs1_data + alu_b;
            3'b010:  alu_out = {{(XLEN-1){1'b0}}, $signed(rs1_data) < $signed(alu_b)};
            3'b100:  alu_out = rs1_data ^ alu_b;
            3'b110:  alu_out = rs1_data | alu_b;
            3'b111:  alu_out = rs1_data & alu_b;
            default: alu_out = '0;
        endcase
    end

    // beq has funct3[0] clear and bne has it set.
    assign take = ex_valid && (opcode == OP_JAL ||
                  (opcode == OP_BRANCH && (funct3[0] ^ (rs1_data == rs2_data))));

    assign stall = ex_valid && opcode == OP_LOAD && !load_wait; // first cycle of a load.

    always_comb begin
        rd_we   = 1'b0;
        rd_data = alu_out;
        if (ex_valid) begin
            case (opcode)
                OP_LUI: begin
                    rd_we   = 1'b1;
                    rd_data = imm_u;
                end
                OP_OPIMM, OP_OP: rd_we = 1'b1;
                OP_JAL: begin
                    rd_we   = 1'b1;
                    rd_data = ex_pc + 32'd4;
                end
                OP_LOAD: begin
                    rd_we   = load_wait; // data returns one cycle after rmem.
                    rd_data = mem.mem_rdata;
                end
                default: rd_we = 1'b0;
            endcase
        end
    end

    assign mem.mem_addr  = rs1_data + ((opcode == OP_STORE) ? imm_s : imm_i);
    assign mem.mem_wdata = rs2_data;
    assign mem.mem_type  = funct3[1:0];
    assign mem.mem_sign  = ~funct3[2];
    assign mem.rmem      = stall;
    assign mem.wmem      = ex_valid && opcode == OP_STORE;

    // re-read the load word so it is still decoded in its second cycle.
    assign inst_addr_rom = stall ? ex_pc[ROM_AW+1:2] : fetch_pc[ROM_AW+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc  <= '0;
            ex_pc     <= '0;
            ex_valid  <= 1'b0;
            load_wait <= 1'b0;
        end else if (stall) begin
            load_wait <= 1'b1;
        end else begin
            load_wait <= 1'b0;
            ex_pc     <= fetch_pc;
            if (take) begin
                fetch_pc <= ex_pc + ((opcode == OP_JAL) ? imm_j : imm_b);
                ex_valid <= 1'b0; // drop the word already fetched.
            end else begin
                fetch_pc <= fetch_pc + 32'd4;
                ex_valid <= 1'b1;
            end
        end
    end
endmodule

// File: rtl/riscv_pkg.sv
package riscv_pkg;

    localparam int XLEN   = 32;
    localparam int ROM_AW = 12;
    localparam int RAM_AW = 13;

    localparam logic [1:0] MEM_BYTE = 2'd0;
    localparam logic [1:0] MEM_HALF = 2'd1;
    localparam logic [1:0] MEM_WORD = 2'd2;

    localparam logic [4:0] OVER_REG = 5'd26;
    localparam logic [4:0] PASS_REG = 5'd27;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_view; // branches share this layout.
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_view; // jal shares this layout.
    } instr_u;

endpackage

// File: rtl/riscv_soc.sv
module riscv_soc (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         prog_wen,
    input  logic [riscv_pkg::ROM_AW-1:0] prog_addr,
    input  logic [riscv_pkg::XLEN-1:0]   prog_data,
    output logic                         over,
    output logic                         pass
);
    import riscv_pkg::*;

    logic [XLEN-1:0]   inst_rom;
    logic [ROM_AW-1:0] inst_addr_rom;

    mem_bus_if  mem_bus ();
    ram_port_if ram_port ();

    riscv_core riscv_inst (
        .clk           (clk),
        .reset         (reset),
        .inst_rom      (inst_rom),
        .inst_addr_rom (inst_addr_rom),
        .over          (over),
        .pass          (pass),
        .mem           (mem_bus.core)
    );

    rom #(.MEM_NUM(2 ** ROM_AW)) rom_inst (
        .clk    (clk),
        .wen    (prog_wen),
        .w_addr (prog_addr),
        .w_data (prog_data),
        .r_addr (inst_addr_rom),
        .r_data (inst_rom)
    );

    ram_interface ram_interface_inst (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_bus.bridge),
        .ram   (ram_port.bridge)
    );

    ram #(.MEM_NUM(2 ** RAM_AW)) ram_inst (
        .clk (clk),
        .ram (ram_port.ram)
    );
endmodule

// File: rtl/rom.sv
module rom #(
    parameter int MEM_NUM = 2 ** riscv_pkg::ROM_AW
) (
    input  logic                         clk,
    input  logic                         wen,
    input  logic [riscv_pkg::ROM_AW-1:0] w_addr,
    input  logic [riscv_pkg::XLEN-1:0]   w_data,
    input  logic [riscv_pkg::ROM_AW-1:0] r_addr,
    output logic [riscv_pkg::XLEN-1:0]   r_data
);
    import riscv_pkg::*;

    logic [XLEN-1:0] mem [MEM_NUM];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[w_addr] <= w_data; // program load, used while the core is in reset.
        end
        r_data <= mem[r_addr];
    end
endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the riscv_soc testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module riscv_soc_tb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vriscv_soc_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" <<< "$output"; then
    exit 0
fi
exit 1

// File: tb/riscv_soc_sva.sv
module riscv_soc_sva (
    input logic       clk,
    input logic       reset,
    input logic       rmem,
    input logic       wmem,
    input logic [1:0] mem_type,
    input logic [3:0] wen
);
    timeunit 1ns;
    timeprecision 1ps;
    import riscv_pkg::*;

    rw_exclusive: assert property (@(posedge clk) disable iff (reset) !(rmem && wmem))
        else $error("rmem and wmem high together");

    byte_one_lane: assert property (@(posedge clk) disable iff (reset)
        (wmem && mem_type == MEM_BYTE) |-> $onehot(wen))
        else $error("byte write enabled %b", wen);

    half_lanes: assert property (@(posedge clk) disable iff (reset)
        (wmem && mem_type == MEM_HALF) |-> (wen == 4'b0011 || wen == 4'b1100))
        else $error("halfword write enabled %b", wen);

    // the first edge of reset still sees the core's unreset state.
    quiet_in_reset: assert property (@(posedge clk) (reset && $past(reset)) |-> wen == 4'b0000)
        else $error("byte enables active during reset");
endmodule

bind ram_interface riscv_soc_sva sva_inst (
    .clk      (clk),
    .reset    (reset),
    .rmem     (mem.rmem),
    .wmem     (mem.wmem),
    .mem_type (mem.mem_type),
    .wen      (ram.wen)
);

// File: tb/riscv_soc_tb.sv
module riscv_soc_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import riscv_pkg::*;

    localparam int NUM_TESTS  = 6;
    localparam int PROG_WORDS = 16;
    localparam int RUN_BUDGET = 30;

    logic              clk;
    logic              reset;
    logic              prog_wen;
    logic [ROM_AW-1:0] prog_addr;
    logic [XLEN-1:0]   prog_data;
    logic              over;
    logic              pass;

    string           names    [NUM_TESTS];
    logic [XLEN-1:0] progs    [NUM_TESTS][PROG_WORDS];
    logic            exp_pass [NUM_TESTS];
    int              n_words;
    int              errors;
    int              failed_tests;

    riscv_soc UUT (
        .clk       (clk),
        .reset     (reset),
        .prog_wen  (prog_wen),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .over      (over),
        .pass      (pass)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * (PROG_WORDS * 2 + 30) * 20);
        $display("Timeout: the tests did not complete in the allowed time.");
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [11:0] imm,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    task automatic emit(input int row, input logic [31:0] word);
        progs[row][n_words] = word;
        n_words++;
    endtask

    task automatic start_row(input int row, input string name, input logic expect_pass);
        names[row]    = name;
        exp_pass[row] = expect_pass;
        n_words       = 0;
        for (int i = 0; i < PROG_WORDS; i++) progs[row][i] = 32'h0;
    endtask

    // lui loads the upper part rounded up when the low twelve bits are negative.
    task automatic emit_const(input int row, input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h800) >> 12;
        emit(row, {hi[19:0], rd, OP_LUI});
        emit(row, enc_i(OP_OPIMM, value[11:0], rd, 3'b000, rd));
    endtask

    task automatic emit_branch(input int row, input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input int target);
        logic [12:0] off;
        off = 13'((target - n_words) * 4);
        emit(row, enc_b(off, rs2, rs1, f3));
    endtask

    task automatic emit_tail(input int row);
        emit(row, enc_i(OP_OPIMM, 12'd1, 5'd0, 3'b000, PASS_REG));
        emit(row, enc_i(OP_OPIMM, 12'd1, 5'd0, 3'b000, OVER_REG)); // branch target on a miss.
        emit(row, enc_jal(21'd0, 5'd0));
    endtask

    task automatic build_random(input int row, input string name, input logic [31:0] a, b,
                                input logic [31:0] bias);
        start_row(row, name, bias == 32'd0);
        emit_const(row, 5'd1, a);
        emit_const(row, 5'd2, b);
        emit(row, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        emit(row, enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd4));
        emit_const(row, 5'd5, a + b + bias);
        emit_branch(row, 3'b001, 5'd3, 5'd5, 13);
        emit_const(row, 5'd6, a ^ b);
        emit_branch(row, 3'b001, 5'd4, 5'd6, 13);
        emit_tail(row);
    endtask

    task automatic build_table();
        logic [31:0] r [1:10];
        logic [31:0] w;
        logic [31:0] merged;
        logic [31:0] ra;
        logic [31:0] rb;
        w = 32'h8F3CA5D6;
        // The ALU chain follows the RV32I definitions of each operation.
        r[1]  = 32'hFFFFFB2E;
        r[2]  = r[1] & 32'h000000F0;
        r[3]  = r[1] | 32'h00000505;
        r[4]  = r[1] ^ 32'hFFFFFFFF;
        r[5]  = ($signed(r[2]) < $signed(r[3])) ? 32'd1 : 32'd0;
        r[6]  = r[4] + r[5];
        r[7]  = r[6] - r[3];
        r[8]  = r[7] & r[1];
        r[9]  = r[8] | r[2];
        r[10] = r[9] ^ r[6];
        start_row(0, "alu", 1'b1);
        emit(0, enc_i(OP_OPIMM, 12'hB2E, 5'd0, 3'b000, 5'd1));
        emit(0, enc_i(OP_OPIMM, 12'h0F0, 5'd1, 3'b111, 5'd2));
        emit(0, enc_i(OP_OPIMM, 12'h505, 5'd1, 3'b110, 5'd3));
        emit(0, enc_i(OP_OPIMM, 12'hFFF, 5'd1, 3'b100, 5'd4));
        emit(0, enc_r(7'h00, 5'd3, 5'd2, 3'b010, 5'd5));
        emit(0, enc_r(7'h00, 5'd5, 5'd4, 3'b000, 5'd6));
        emit(0, enc_r(7'h20, 5'd3, 5'd6, 3'b000, 5'd7));
        emit(0, enc_r(7'h00, 5'd1, 5'd7, 3'b111, 5'd8));
        emit(0, enc_r(7'h00, 5'd2, 5'd8, 3'b110, 5'd9));
        emit(0, enc_r(7'h00, 5'd6, 5'd9, 3'b100, 5'd10));
        emit_const(0, 5'd12, r[10]);
        emit_branch(0, 3'b001, 5'd10, 5'd12, 14);
        emit_tail(0);
        // lb reads byte 1, lbu byte 3, lh the upper half and lhu the lower half.
        r[1] = {{24{w[15]}}, w[15:8]};
        r[2] = {24'h0, w[31:24]};
        r[3] = {{16{w[31]}}, w[31:16]};
        r[4] = {16'h0, w[15:0]};
        start_row(1, "mem_load", 1'b1);
        emit_const(1, 5'd1, w);
        emit(1, enc_s(12'h100, 5'd1, 5'd0, 3'b010));
        emit(1, enc_i(OP_LOAD, 12'h101, 5'd0, 3'b000, 5'd2));
        emit(1, enc_i(OP_LOAD, 12'h103, 5'd0, 3'b100, 5'd3));
        emit(1, enc_i(OP_LOAD, 12'h102, 5'd0, 3'b001, 5'd4));
        emit(1, enc_i(OP_LOAD, 12'h100, 5'd0, 3'b101, 5'd5));
        emit(1, enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd6));
        emit(1, enc_r(7'h00, 5'd4, 5'd6, 3'b100, 5'd6));
        emit(1, enc_r(7'h00, 5'd5, 5'd6, 3'b000, 5'd6));
        emit_const(1, 5'd7, ((r[1] + r[2]) ^ r[3]) + r[4]);
        emit_branch(1, 3'b001, 5'd6, 5'd7, 14);
        emit_tail(1);
        // sb puts 0x5a in byte 1 and sh puts 0xfffe in the upper half before lw and lh.
        merged = {16'hFFFE, 8'h5A, w[7:0]};
        start_row(2, "mem_store", 1'b1);
        emit_const(2, 5'd1, w);
        emit(2, enc_s(12'h100, 5'd1, 5'd0, 3'b010));
        emit(2, enc_i(OP_OPIMM, 12'h05A, 5'd0, 3'b000, 5'd2));
        emit(2, enc_i(OP_OPIMM, 12'hFFE, 5'd0, 3'b000, 5'd3));
        emit(2, enc_s(12'h101, 5'd2, 5'd0, 3'b000));
        emit(2, enc_s(12'h102, 5'd3, 5'd0, 3'b001));
        emit(2, enc_i(OP_LOAD, 12'h100, 5'd0, 3'b010, 5'd4));
        emit(2, enc_i(OP_LOAD, 12'h102, 5'd0, 3'b001, 5'd5));
        emit(2, enc_r(7'h00, 5'd5, 5'd4, 3'b000, 5'd4));
        emit_const(2, 5'd6, merged + 32'hFFFFFFFE);
        emit_branch(2, 3'b001, 5'd4, 5'd6, 14);
        emit_tail(2);
        // x4 must stay zero since both writes to it sit in branch shadows.
        start_row(3, "control", 1'b1);
        emit(3, enc_i(OP_OPIMM, 12'd5, 5'd0, 3'b000, 5'd1));
        emit(3, enc_i(OP_OPIMM, 12'd5, 5'd0, 3'b000, 5'd2));
        emit_branch(3, 3'b000, 5'd1, 5'd0, 14);
        emit_branch(3, 3'b001, 5'd1, 5'd2, 14);
        emit_branch(3, 3'b000, 5'd1, 5'd2, 6);
        emit(3, enc_i(OP_OPIMM, 12'd1, 5'd0, 3'b000, 5'd4));
        emit_branch(3, 3'b001, 5'd1, 5'd0, 8);
        emit(3, enc_i(OP_OPIMM, 12'd2, 5'd0, 3'b000, 5'd4));
        emit(3, enc_jal(21'd8, 5'd5));
        emit(3, enc_jal(21'd20, 5'd0)); // this trap jumps to the fail path.
        emit_branch(3, 3'b001, 5'd4, 5'd0, 14);
        emit(3, enc_i(OP_OPIMM, 12'd36, 5'd0, 3'b000, 5'd6));
        emit_branch(3, 3'b001, 5'd5, 5'd6, 14);
        emit_tail(3);
        ra = $urandom;
        rb = $urandom;
        build_random(4, "random", ra, rb, 32'd0);
        build_random(5, "wrong_const", ra, rb, 32'd1);
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic run_test(input int row);
        int cycles;
        int errors_before;
        errors_before = errors;
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(negedge clk);
            prog_wen  = 1'b1;
            prog_addr = ROM_AW'(i);
            prog_data = progs[row][i];
        end
        @(negedge clk);
        prog_wen = 1'b0;
        repeat (4) @(negedge clk);
        check_flag("over", over, 1'b0);
        check_flag("pass", pass, 1'b0);
        reset = 1'b0;
        @(negedge clk);
        check_flag("over", over, 1'b0); // far too early for x26 to be written.
        check_flag("pass", pass, 1'b0);
        cycles = 0;
        while (over !== 1'b1 && cycles < RUN_BUDGET) begin
            @(negedge clk);
            cycles++;
        end
        if (over !== 1'b1) begin
            $display("test %s: over did not rise within %0d cycles", names[row], RUN_BUDGET);
            errors++;
        end else begin
            check_flag("pass", pass, exp_pass[row]);
        end
        if (errors == errors_before) begin
            $display("test %s: ok after %0d cycles", names[row], cycles);
        end else begin
            $display("test %s: failed", names[row]);
            failed_tests++;
        end
    endtask

    initial begin
        reset        = 1'b1;
        prog_wen     = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        errors       = 0;
        failed_tests = 0;
        void'($urandom(32'h73808e75));
        build_table();
        for (int row = 0; row < NUM_TESTS; row++) begin
            run_test(row);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, NUM_TESTS - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end
endmodule
